// File: Makefile
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= outrun_main_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: cabinet/outrun_cab_read.sv
// Cabinet read multiplexer with switch, DIP and ADC conversion rules for both games
`timescale 1ns/1ps

module outrun_cab_read (
    input  logic [1:0]           game_id,
    input  logic [2:0]           ctrl_type,
    input  logic                 io_cs,
    input  outrun_pkg::io_addr_t addr,
    input  logic                 rnw,
    input  logic [7:0]           port_c,
    input  logic [2:0]           adc_ch,
    input  logic [15:0]          dacana1,
    input  logic [15:0]          dacana1b,
    input  logic [7:0]           joystick1,
    input  logic [1:0]           start_button,
    input  logic [1:0]           coin_input,
    input  logic                 service,
    input  logic                 dip_test,
    input  logic [7:0]           dipsw_a,
    input  logic [7:0]           dipsw_b,
    output logic [7:0]           cab_dout,
    output logic                 obj_toggle
);
    import outrun_pkg::*;

    logic [7:0] wheel_val;
    logic [7:0] pedal;
    logic [7:0] stick_gas;
    logic [7:0] stick_brake;
    logic [7:0] trig_gas;
    logic [7:0] or_adc;
    logic [7:0] sho_adc;
    logic [2:0] sho_bank;

    assign wheel_val   = dacana1[7:0] ^ 8'h80;                // Centre at 8'h80
    assign pedal       = {dacana1b[14:8], dacana1b[14]};
    assign stick_gas   = dacana1b[15] ? ~pedal : 8'h00;      // Stick pushed up
    assign stick_brake = dacana1b[15] ? 8'h00 : pedal;
    assign trig_gas    = dacana1b[7] ? 8'h00 : {dacana1b[6:0], dacana1b[6]};
    assign sho_bank    = {addr.sho_view.bank_hi, addr.sho_view.bank_lo};

    // Out Run ADC where digital buttons win over the analog value
    always_comb begin
        or_adc = open_bus;
        case (adc_ch)
            adc_wheel: begin
                if (!joystick1[1])      or_adc = 8'h20;
                else if (!joystick1[0]) or_adc = 8'he0;
                else                    or_adc = wheel_val;
            end
            adc_gas: begin
                case (ctrl_type)
                    ctrl_stick, ctrl_wheel: or_adc = stick_gas;
                    ctrl_trigger:           or_adc = trig_gas;
                    default:                or_adc = 8'h00;
                endcase
                if (!joystick1[5]) or_adc = 8'hff;
            end
            adc_brake: begin
                case (ctrl_type)
                    ctrl_stick, ctrl_trigger: or_adc = stick_brake;
                    ctrl_wheel:               or_adc = stick_gas; // Second pedal on same axis
                    default:                  or_adc = 8'h00;
                endcase
                if (!joystick1[6]) or_adc = 8'hff;
            end
            adc_motor: or_adc = open_bus; // No motor feedback
            default:   or_adc = open_bus;
        endcase
    end

    always_comb begin
        case (adc_ch)
            adc_wheel: sho_adc = !joystick1[0] ? 8'h20 : !joystick1[1] ? 8'hd0 : wheel_val;
            adc_gas:   sho_adc = !joystick1[3] ? 8'hf0 : stick_gas;
            adc_brake: sho_adc = !joystick1[2] ? 8'hf0 : stick_brake;
            default:   sho_adc = open_bus;
        endcase
    end

    always_comb begin
        cab_dout   = open_bus;
        obj_toggle = 1'b0;
        if (io_cs && game_id == game_outrun) begin
            case (addr.or_view.bank)
                3'd0: if (addr.or_view.reg_sel == 2'd2 && rnw) cab_dout = port_c;
                3'd1: if (rnw) begin
                    case (addr.or_view.reg_sel)
                        2'd0: cab_dout = {coin_input, ~joystick1[7], joystick1[7],
                                          start_button[0], service, dip_test, 1'b1};
                        2'd2: cab_dout = dipsw_a;
                        2'd3: cab_dout = dipsw_b;
                        default: cab_dout = open_bus;
                    endcase
                end
                3'd3: if (rnw) cab_dout = or_adc;
                3'd7: obj_toggle = 1'b1; // Any access swaps object buffers
                default: ;
            endcase
        end else if (io_cs && game_id == game_shangon && rnw) begin
            case (sho_bank)
                3'd2: begin
                    case (addr.sho_view.reg_sel)
                        2'd1: cab_dout = {2'b11, joystick1[4], start_button[0], service,
                                          dip_test, coin_input};
                        2'd2: cab_dout = dipsw_a;
                        2'd3: cab_dout = dipsw_b;
                        default: cab_dout = open_bus;
                    endcase
                end
                3'd7: cab_dout = sho_adc;
                default: ;
            endcase
        end
    end

endmodule

// File: cabinet/outrun_io_ctrl.sv
// Cabinet control register, ADC channel select and analog sample latches for both games
`timescale 1ns/1ps

module outrun_io_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [1:0]           game_id,
    input  logic                 io_cs,
    input  outrun_pkg::io_addr_t addr,
    input  logic                 ldsn,
    input  logic                 rnw,
    input  logic [15:0]          cpu_dout,
    input  logic [15:0]          joyana1,
    input  logic [15:0]          joyana1b,
    output logic [7:0]           port_c,
    output logic [2:0]           adc_ch,
    output logic [15:0]          dacana1,
    output logic [15:0]          dacana1b,
    output logic                 video_en,
    output logic [1:0]           obj_cfg,
    output logic                 snd_rstb
);
    import outrun_pkg::*;

    logic       is_outrun;
    logic       is_shangon;
    logic       io_wr;    // Low byte write into I/O space
    logic [2:0] sho_bank;
    logic       adc_wr;
    logic [2:0] sho_adc_ch;
    logic       sho_video_en;
    logic       sho_snd_rstb;

    assign is_outrun  = game_id == game_outrun;
    assign is_shangon = game_id == game_shangon;
    assign io_wr      = io_cs && !ldsn && !rnw;
    assign sho_bank   = {addr.sho_view.bank_hi, addr.sho_view.bank_lo};

    // Sample the analog inputs when the CPU starts a conversion
    assign adc_wr = io_wr && ((is_outrun && addr.or_view.bank == 3'd3) ||
                              (is_shangon && sho_bank == 3'd7));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            port_c       <= 8'h21; // Video on, sound out of reset
            sho_adc_ch   <= 3'd0;
            sho_video_en <= 1'b1;
            sho_snd_rstb <= 1'b1;
        end else if (io_wr) begin
            if (is_outrun && addr.or_view.bank == 3'd0 && addr.or_view.reg_sel == 2'd2) begin
                port_c <= cpu_dout[7:0];
            end
            if (is_shangon && sho_bank == 3'd0) begin
                sho_adc_ch   <= {1'b0, cpu_dout[7:6]};
                sho_video_en <= cpu_dout[4];
            end
            if (is_shangon && sho_bank == 3'd1) begin
                sho_snd_rstb <= ~cpu_dout[0]; // Active high reset bit on this board
            end
        end
    end

    always_ff @(posedge clk) begin
        if (adc_wr) begin
            dacana1  <= joyana1;
            dacana1b <= joyana1b;
        end
    end

    // Out Run takes its controls straight from port C
    assign obj_cfg  = port_c[7:6];
    assign video_en = is_shangon ? sho_video_en : port_c[5];
    assign adc_ch   = is_shangon ? sho_adc_ch   : port_c[4:2];
    assign snd_rstb = is_shangon ? sho_snd_rstb : port_c[0];

endmodule

// File: common/outrun_pkg.sv
// Region bits, game and controller codes, ADC channels and the I/O address views
package outrun_pkg;

    // Bit positions in the one-hot region vector from the mapper
    localparam logic [2:0] reg_mem = 3'd0;
    localparam logic [2:0] reg_scr = 3'd1;
    localparam logic [2:0] reg_pal = 3'd2;
    localparam logic [2:0] reg_obj = 3'd3;
    localparam logic [2:0] reg_io  = 3'd4;
    localparam logic [2:0] reg_sub = 3'd5;

    localparam logic [1:0] game_outrun  = 2'd0;
    localparam logic [1:0] game_shangon = 2'd1;

    // Pedal mapping per controller
    localparam logic [2:0] ctrl_stick   = 3'd0;
    localparam logic [2:0] ctrl_trigger = 3'd1;
    localparam logic [2:0] ctrl_wheel   = 3'd2;

    localparam logic [2:0] adc_wheel = 3'd0;
    localparam logic [2:0] adc_gas   = 3'd1;
    localparam logic [2:0] adc_brake = 3'd2;
    localparam logic [2:0] adc_motor = 3'd3;

    localparam logic [7:0] open_bus   = 8'hff;
    localparam logic [2:0] fc_int_ack = 3'd7; // 68000 interrupt acknowledge

    // Out Run I/O layout over word address bits 13..1
    typedef struct packed {
        logic [6:0] unused_hi; // Bits 13..7
        logic [2:0] bank;      // Bits 6..4
        logic       unused_b3;
        logic [1:0] reg_sel;   // Bits 2..1
    } or_io_t;

    // Super Hang On I/O layout with the bank split over 13..12 and 5
    typedef struct packed {
        logic [1:0] bank_hi;    // Bits 13..12
        logic [5:0] unused_mid; // Bits 11..6
        logic       bank_lo;    // Bit 5
        logic [1:0] unused_lo;  // Bits 4..3
        logic [1:0] reg_sel;    // Bits 2..1
    } sho_io_t;

    typedef union packed {
        or_io_t  or_view;
        sho_io_t sho_view;
    } io_addr_t;

endpackage

// File: dv/outrun_main_tb.sv
// Directed testbench for outrun_main with bus tasks, compare tasks, reference models and watchdog
`timescale 1ns/1ps

module outrun_main_tb;
    import outrun_pkg::*;

    localparam int num_tests = 6;
    localparam int test_ns   = 2000; // Budget per test for the watchdog

    logic        clk;
    logic        rst;
    logic [19:1] addr;
    logic [7:0]  region;
    logic [2:0]  fc;
    logic        asn;
    logic        udsn;
    logic        ldsn;
    logic        rnw;
    logic [15:0] cpu_dout;
    logic [15:0] rom_data;
    logic [15:0] ram_data;
    logic [15:0] char_dout;
    logic [15:0] pal_dout;
    logic [15:0] obj_dout;
    logic [15:0] sub_din;
    logic [1:0]  game_id;
    logic [2:0]  ctrl_type;
    logic [7:0]  joystick1;
    logic [15:0] joyana1;
    logic [15:0] joyana1b;
    logic [1:0]  start_button;
    logic [1:0]  coin_input;
    logic        service;
    logic        dip_test;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic        rom_cs;
    logic        ram_cs;
    logic        vram_cs;
    logic        char_cs;
    logic        objram_cs;
    logic        pal_cs;
    logic        sub_cs;
    logic [15:0] cpu_din;
    logic        video_en;
    logic [1:0]  obj_cfg;
    logic        snd_rstb;
    logic        obj_toggle;

    logic [31:0] rng_state;
    logic [6:0]  cs_seen;     // rom, ram, vram, char, obj, pal, sub
    logic        toggle_seen;
    logic [15:0] din_seen;

    outrun_main i_outrun_main (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_cfg(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    // One bus cycle held for three clocks with selects and read data sampled at falling edges
    task automatic bus_cycle(input logic [19:1] a, input logic [7:0] rgn, input logic [2:0] f,
                             input logic as_on, input logic rd, input logic [15:0] wdata);
        @(posedge clk);
        #1;
        addr     = a;
        region   = rgn;
        fc       = f;
        rnw      = rd;
        cpu_dout = wdata;
        asn      = !as_on;
        udsn     = !as_on;
        ldsn     = !as_on;
        @(posedge clk);
        @(negedge clk);
        cs_seen     = {rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, sub_cs};
        toggle_seen = obj_toggle;
        @(posedge clk);
        @(negedge clk);
        din_seen = cpu_din;
        @(posedge clk);
        #1;
        asn    = 1'b1;
        udsn   = 1'b1;
        ldsn   = 1'b1;
        rnw    = 1'b1;
        region = 8'h00;
    endtask

    task automatic io_write(input logic [19:1] a, input logic [15:0] d);
        bus_cycle(a, 8'b1 << reg_io, 3'd5, 1'b1, 1'b0, d);
    endtask

    task automatic io_read(input logic [19:1] a);
        bus_cycle(a, 8'b1 << reg_io, 3'd5, 1'b1, 1'b1, 16'h0000);
    endtask

    function automatic logic [19:1] or_io_addr(input logic [2:0] bank, input logic [1:0] rsel);
        logic [19:1] a;
        a      = '0;
        a[6:4] = bank;
        a[2:1] = rsel;
        return a;
    endfunction

    // Bank bits 13, 12 and 5
    function automatic logic [19:1] sho_io_addr(input logic [2:0] bank, input logic [1:0] rsel);
        logic [19:1] a;
        a        = '0;
        a[13:12] = bank[2:1];
        a[5]     = bank[0];
        a[2:1]   = rsel;
        return a;
    endfunction

    function automatic logic [7:0] wheel_of(input logic [15:0] a1);
        return {~a1[7], a1[6:0]};
    endfunction

    function automatic logic [7:0] pedal_of(input logic [15:0] a1b);
        return {a1b[14:8], a1b[14]};
    endfunction

    function automatic logic [7:0] or_adc_expect(input logic [2:0] ch, input logic [2:0] ctrl,
                                                 input logic [7:0] joy, input logic [15:0] a1,
                                                 input logic [15:0] a1b);
        logic [7:0] up_gas;
        logic [7:0] res;
        up_gas = a1b[15] ? ~pedal_of(a1b) : 8'h00;
        res    = 8'hff;
        if (ch == adc_wheel) begin
            res = !joy[1] ? 8'h20 : (!joy[0] ? 8'he0 : wheel_of(a1));
        end else if (ch == adc_gas) begin
            if (!joy[5])                   res = 8'hff;
            else if (ctrl == ctrl_trigger) res = a1b[7] ? 8'h00 : {a1b[6:0], a1b[6]};
            else                           res = up_gas;
        end else if (ch == adc_brake) begin
            if (!joy[6])                 res = 8'hff;
            else if (ctrl == ctrl_wheel) res = up_gas;
            else                         res = a1b[15] ? 8'h00 : pedal_of(a1b);
        end
        return res;
    endfunction

    function automatic logic [7:0] sho_adc_expect(input logic [2:0] ch, input logic [7:0] joy,
                                                  input logic [15:0] a1, input logic [15:0] a1b);
        logic [7:0] res;
        res = 8'hff;
        if (ch == adc_wheel)
            res = !joy[0] ? 8'h20 : (!joy[1] ? 8'hd0 : wheel_of(a1));
        else if (ch == adc_gas)
            res = !joy[3] ? 8'hf0 : (a1b[15] ? ~pedal_of(a1b) : 8'h00);
        else if (ch == adc_brake)
            res = !joy[2] ? 8'hf0 : (a1b[15] ? 8'h00 : pedal_of(a1b));
        return res;
    endfunction

    // Joystick bits pulled low to force a digital override
    function automatic logic [7:0] override_mask(input logic sho, input int ch, input int v);
        logic [7:0] m;
        m = 8'h00;
        if (v != 0) begin
            case (ch)
                0:       m = sho ? (v == 1 ? 8'h01 : 8'h02) : (v == 1 ? 8'h02 : 8'h01);
                1:       m = sho ? 8'h08 : 8'h20;
                2:       m = sho ? 8'h04 : 8'h40;
                default: m = 8'h00;
            endcase
        end
        return m;
    endfunction

    task automatic randomize_sources();
        logic [31:0] rnd;
        rnd       = xorshift32();
        rom_data  = rnd[15:0];
        ram_data  = rnd[31:16];
        rnd       = xorshift32();
        char_dout = rnd[15:0];
        pal_dout  = rnd[31:16];
        rnd       = xorshift32();
        obj_dout  = rnd[15:0];
        sub_din   = rnd[31:16];
    endtask

    task automatic decode_case(input string name, input logic [19:1] a, input logic [7:0] rgn,
                               input int idx, input logic [15:0] exp);
        logic [6:0] others;
        bus_cycle(a, rgn, 3'd5, 1'b1, 1'b1, 16'h0000);
        others      = cs_seen;
        others[idx] = 1'b0;
        check_bit(name, cs_seen[idx], 1'b1);
        check_bit("unselected chip selects", |others, 1'b0);
        check_word("cpu_din", din_seen, exp);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_bit("video_en", video_en, 1'b1);
        check_bit("snd_rstb", snd_rstb, 1'b1);
        check_cfg("obj_cfg", obj_cfg, 2'b00);
        check_bit("obj_toggle", obj_toggle, 1'b0);
        check_bit("chip selects", rom_cs | ram_cs | vram_cs | char_cs | objram_cs | pal_cs | sub_cs,
                  1'b0);
        check_word("cpu_din", cpu_din, 16'hffff);
        @(posedge clk);
        #1;
    endtask

    task automatic test_region_decode();
        logic [19:1] a;
        logic [31:0] rnd;
        rnd = xorshift32();
        a   = rnd[18:0];
        randomize_sources();
        a[18:17] = 2'b01;
        decode_case("rom_cs", a, 8'b1 << reg_mem, 6, rom_data);
        randomize_sources();
        a[18:17] = 2'b10;
        decode_case("rom_cs", a, 8'b1 << reg_mem, 6, rom_data);
        randomize_sources();
        a[18:17] = 2'b11;
        decode_case("ram_cs", a, 8'b1 << reg_mem, 5, ram_data);
        randomize_sources();
        a[16] = 1'b0;
        decode_case("vram_cs", a, 8'b1 << reg_scr, 4, ram_data);
        randomize_sources();
        a[16] = 1'b1;
        decode_case("char_cs", a, 8'b1 << reg_scr, 3, char_dout);
        randomize_sources();
        decode_case("objram_cs", a, 8'b1 << reg_obj, 2, obj_dout);
        randomize_sources();
        decode_case("pal_cs", a, 8'b1 << reg_pal, 1, pal_dout);
        randomize_sources();
        decode_case("sub_cs", a, 8'b1 << reg_sub, 0, sub_din);
        // Interrupt acknowledge, then an idle bus
        bus_cycle(a, 8'b1 << reg_mem, fc_int_ack, 1'b1, 1'b1, 16'h0000);
        check_bit("chip selects", |cs_seen, 1'b0);
        check_word("cpu_din", din_seen, 16'hffff);
        bus_cycle(a, 8'b1 << reg_pal, 3'd5, 1'b0, 1'b1, 16'h0000);
        check_bit("chip selects", |cs_seen, 1'b0);
        check_word("cpu_din", din_seen, 16'hffff);
    endtask

    task automatic test_or_switches();
        logic [31:0] rnd;
        logic [7:0]  exp_sw;
        game_id = game_outrun;
        for (int n = 0; n < 3; n++) begin
            rnd          = xorshift32();
            joystick1    = rnd[7:0];
            start_button = rnd[9:8];
            coin_input   = rnd[11:10];
            service      = rnd[12];
            dip_test     = rnd[13];
            dipsw_a      = rnd[23:16];
            dipsw_b      = rnd[31:24];
            exp_sw = {coin_input, ~joystick1[7], joystick1[7], start_button[0], service,
                      dip_test, 1'b1};
            io_read(or_io_addr(3'd1, 2'd0));
            check_word("cpu_din", din_seen, {8'hff, exp_sw});
            io_read(or_io_addr(3'd1, 2'd1));
            check_word("cpu_din", din_seen, 16'hffff);
            io_read(or_io_addr(3'd1, 2'd2));
            check_word("cpu_din", din_seen, {8'hff, dipsw_a});
            io_read(or_io_addr(3'd1, 2'd3));
            check_word("cpu_din", din_seen, {8'hff, dipsw_b});
        end
        joystick1 = 8'hff;
    endtask

    task automatic test_or_control();
        logic [31:0] rnd;
        logic [7:0]  b;
        game_id = game_outrun;
        for (int n = 0; n < 3; n++) begin
            rnd = xorshift32();
            b   = (n == 1) ? ~b : rnd[7:0]; // Second pass toggles every field
            io_write(or_io_addr(3'd0, 2'd2), rnd[31:16] & 16'hff00 | {8'h00, b});
            check_cfg("obj_cfg", obj_cfg, b[7:6]);
            check_bit("video_en", video_en, b[5]);
            check_bit("snd_rstb", snd_rstb, b[0]);
            io_read(or_io_addr(3'd0, 2'd2));
            check_word("cpu_din", din_seen, {8'hff, b});
            io_read(or_io_addr(3'd0, 2'd1));
            check_word("cpu_din", din_seen, 16'hffff);
            check_bit("obj_toggle", toggle_seen, 1'b0);
            io_read(or_io_addr(3'd7, 2'd0));
            check_bit("obj_toggle", toggle_seen, 1'b1);
        end
        io_write(or_io_addr(3'd0, 2'd2), 16'h0021);
    endtask

    task automatic test_or_adc();
        logic [31:0] rnd;
        logic [7:0]  exp_adc;
        game_id = game_outrun;
        for (int ct = 0; ct < 3; ct++) begin
            for (int ch = 0; ch < 4; ch++) begin
                for (int v = 0; v < 3; v++) begin
                    if (ch == 3 && v != 0) continue; // Motor channel has no override
                    io_write(or_io_addr(3'd0, 2'd2), {8'h00, 2'b00, 1'b1, 3'(ch), 2'b01});
                    ctrl_type = 3'(ct);
                    rnd       = xorshift32();
                    joystick1 = (rnd[7:0] | 8'h63) & ~override_mask(1'b0, ch, v);
                    rnd       = xorshift32();
                    joyana1   = rnd[15:0];
                    joyana1b  = rnd[31:16];
                    io_write(or_io_addr(3'd3, 2'd0), 16'h0000); // Start conversion
                    exp_adc = or_adc_expect(3'(ch), ctrl_type, joystick1, joyana1, joyana1b);
                    io_read(or_io_addr(3'd3, 2'd0));
                    check_word("cpu_din", din_seen, {8'hff, exp_adc});
                end
            end
        end
        joystick1 = 8'hff;
    endtask

    task automatic test_shangon();
        logic [31:0] rnd;
        logic [7:0]  exp_val;
        game_id = game_shangon;
        rnd = xorshift32();
        // Second pass writes the complement so both levels are seen
        for (int n = 0; n < 2; n++) begin
            io_write(sho_io_addr(3'd0, 2'd0), rnd[15:0]);
            check_bit("video_en", video_en, rnd[4]);
            io_write(sho_io_addr(3'd1, 2'd0), rnd[31:16]);
            check_bit("snd_rstb", snd_rstb, ~rnd[16]);
            rnd = ~rnd;
        end
        rnd          = xorshift32();
        joystick1    = rnd[7:0];
        start_button = rnd[9:8];
        coin_input   = rnd[11:10];
        service      = rnd[12];
        dip_test     = rnd[13];
        dipsw_a      = rnd[23:16];
        dipsw_b      = rnd[31:24];
        exp_val = {2'b11, joystick1[4], start_button[0], service, dip_test, coin_input};
        io_read(sho_io_addr(3'd2, 2'd0));
        check_word("cpu_din", din_seen, 16'hffff);
        io_read(sho_io_addr(3'd2, 2'd1));
        check_word("cpu_din", din_seen, {8'hff, exp_val});
        io_read(sho_io_addr(3'd2, 2'd2));
        check_word("cpu_din", din_seen, {8'hff, dipsw_a});
        io_read(sho_io_addr(3'd2, 2'd3));
        check_word("cpu_din", din_seen, {8'hff, dipsw_b});
        for (int ch = 0; ch < 3; ch++) begin
            for (int v = 0; v < 3; v++) begin
                if (ch != 0 && v == 2) continue;
                io_write(sho_io_addr(3'd0, 2'd0), {8'h00, 2'(ch), 2'b01, 4'h0});
                rnd       = xorshift32();
                joystick1 = (rnd[7:0] | 8'h0f) & ~override_mask(1'b1, ch, v);
                rnd       = xorshift32();
                joyana1   = rnd[15:0];
                joyana1b  = rnd[31:16];
                io_write(sho_io_addr(3'd7, 2'd0), 16'h0000);
                exp_val = sho_adc_expect(3'(ch), joystick1, joyana1, joyana1b);
                io_read(sho_io_addr(3'd7, 2'd0));
                check_word("cpu_din", din_seen, {8'hff, exp_val});
            end
        end
    endtask

    initial begin
        #(num_tests * test_ns);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin
        rng_state    = 32'd26;
        clk          = 1'b0;
        rst          = 1'b1;
        addr         = '0;
        region       = 8'h00;
        fc           = 3'd0;
        asn          = 1'b1;
        udsn         = 1'b1;
        ldsn         = 1'b1;
        rnw          = 1'b1;
        cpu_dout     = 16'h0000;
        rom_data     = 16'h0000;
        ram_data     = 16'h0000;
        char_dout    = 16'h0000;
        pal_dout     = 16'h0000;
        obj_dout     = 16'h0000;
        sub_din      = 16'h0000;
        game_id      = game_outrun;
        ctrl_type    = ctrl_stick;
        joystick1    = 8'hff; // Active low buttons released
        joyana1      = 16'h0000;
        joyana1b     = 16'h0000;
        start_button = 2'b00;
        coin_input   = 2'b00;
        service      = 1'b0;
        dip_test     = 1'b0;
        dipsw_a      = 8'h00;
        dipsw_b      = 8'h00;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_region_decode();
        test_or_switches();
        test_or_control();
        test_or_adc();
        test_shangon();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: flist.f
common/outrun_pkg.sv
verilog/outrun_bus_decode.sv
cabinet/outrun_io_ctrl.sv
cabinet/outrun_cab_read.sv
verilog/outrun_data_mux.sv
verilog/outrun_main.sv
dv/outrun_main_tb.sv

// File: verilog/outrun_bus_decode.sv
// Registered chip select decode from address, region vector, function code and strobes
`timescale 1ns/1ps

module outrun_bus_decode (
    input  logic        clk,
    input  logic        rst,
    input  logic [19:1] addr,
    input  logic [7:0]  region,
    input  logic [2:0]  fc,
    input  logic        asn,
    input  logic        udsn,
    input  logic        ldsn,
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        vram_cs,
    output logic        char_cs,
    output logic        objram_cs,
    output logic        pal_cs,
    output logic        io_cs,
    output logic        sub_cs
);
    import outrun_pkg::*;

    logic bus_valid;
    logic ds_active;
    logic ram_page; // Top 128k of the mem region

    assign bus_valid = !asn && fc != fc_int_ack;
    assign ds_active = !(udsn && ldsn);
    assign ram_page  = addr[18:17] == 2'b11;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            objram_cs <= 1'b0;
            pal_cs    <= 1'b0;
            io_cs     <= 1'b0;
            sub_cs    <= 1'b0;
        end else if (bus_valid) begin
            rom_cs    <= region[reg_mem] && !ram_page;
            ram_cs    <= region[reg_mem] && ram_page && ds_active;
            char_cs   <= region[reg_scr] && addr[16];
            vram_cs   <= region[reg_scr] && !addr[16] && ds_active; // Tile RAM
            objram_cs <= region[reg_obj];
            pal_cs    <= region[reg_pal];
            io_cs     <= region[reg_io];
            sub_cs    <= region[reg_sub];
        end else begin
            // Idle bus or interrupt acknowledge
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            objram_cs <= 1'b0;
            pal_cs    <= 1'b0;
            io_cs     <= 1'b0;
            sub_cs    <= 1'b0;
        end
    end

endmodule

// File: verilog/outrun_data_mux.sv
// Registered CPU read data selection across memory, video, sub-CPU and cabinet sources
`timescale 1ns/1ps

module outrun_data_mux (
    input  logic        clk,
    input  logic        rst,
    input  logic        rom_cs,
    input  logic        ram_cs,
    input  logic        vram_cs,
    input  logic        char_cs,
    input  logic        objram_cs,
    input  logic        pal_cs,
    input  logic        io_cs,
    input  logic        sub_cs,
    input  logic [15:0] ram_data,   // Shared by work RAM and VRAM
    input  logic [15:0] rom_data,
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    input  logic [15:0] sub_din,
    input  logic [7:0]  cab_dout,
    output logic [15:0] cpu_din
);
    import outrun_pkg::*;

    // Priority order follows the board's read path
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 16'hffff;
        end else begin
            if (ram_cs || vram_cs) cpu_din <= ram_data;
            else if (rom_cs)       cpu_din <= rom_data; // No decryption
            else if (char_cs)      cpu_din <= char_dout;
            else if (pal_cs)       cpu_din <= pal_dout;
            else if (objram_cs)    cpu_din <= obj_dout;
            else if (sub_cs)       cpu_din <= sub_din;
            else if (io_cs)        cpu_din <= {open_bus, cab_dout};
            else                   cpu_din <= 16'hffff;
        end
    end

endmodule

// File: verilog/outrun_main.sv
// Top level joining bus decode, cabinet control, cabinet read and CPU data mux
`timescale 1ns/1ps

module outrun_main (
    input  logic        clk,
    input  logic        rst,
    // Bus cycle
    input  logic [19:1] addr,
    input  logic [7:0]  region,
    input  logic [2:0]  fc,
    input  logic        asn,
    input  logic        udsn,
    input  logic        ldsn,
    input  logic        rnw,
    input  logic [15:0] cpu_dout,
    // Read sources
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    input  logic [15:0] sub_din,
    // Cabinet
    input  logic [1:0]  game_id,
    input  logic [2:0]  ctrl_type,
    input  logic [7:0]  joystick1,
    input  logic [15:0] joyana1,
    input  logic [15:0] joyana1b,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        vram_cs,
    output logic        char_cs,
    output logic        objram_cs,
    output logic        pal_cs,
    output logic        sub_cs,
    output logic [15:0] cpu_din,
    output logic        video_en,
    output logic [1:0]  obj_cfg,
    output logic        snd_rstb,
    output logic        obj_toggle
);

    logic        io_cs;
    logic [7:0]  port_c;
    logic [2:0]  adc_ch;
    logic [15:0] dacana1;
    logic [15:0] dacana1b;
    logic [7:0]  cab_dout;

    outrun_bus_decode i_bus_decode (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .region    (region),
        .fc        (fc),
        .asn       (asn),
        .udsn      (udsn),
        .ldsn      (ldsn),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .objram_cs (objram_cs),
        .pal_cs    (pal_cs),
        .io_cs     (io_cs),
        .sub_cs    (sub_cs)
    );

    outrun_io_ctrl i_io_ctrl (
        .clk      (clk),
        .rst      (rst),
        .game_id  (game_id),
        .io_cs    (io_cs),
        .addr     (addr[13:1]),
        .ldsn     (ldsn),
        .rnw      (rnw),
        .cpu_dout (cpu_dout),
        .joyana1  (joyana1),
        .joyana1b (joyana1b),
        .port_c   (port_c),
        .adc_ch   (adc_ch),
        .dacana1  (dacana1),
        .dacana1b (dacana1b),
        .video_en (video_en),
        .obj_cfg  (obj_cfg),
        .snd_rstb (snd_rstb)
    );

    outrun_cab_read i_cab_read (
        .game_id      (game_id),
        .ctrl_type    (ctrl_type),
        .io_cs        (io_cs),
        .addr         (addr[13:1]),
        .rnw          (rnw),
        .port_c       (port_c),
        .adc_ch       (adc_ch),
        .dacana1      (dacana1),
        .dacana1b     (dacana1b),
        .joystick1    (joystick1),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cab_dout     (cab_dout),
        .obj_toggle   (obj_toggle)
    );

    outrun_data_mux i_data_mux (
        .clk       (clk),
        .rst       (rst),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .objram_cs (objram_cs),
        .pal_cs    (pal_cs),
        .io_cs     (io_cs),
        .sub_cs    (sub_cs),
        .ram_data  (ram_data),
        .rom_data  (rom_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .sub_din   (sub_din),
        .cab_dout  (cab_dout),
        .cpu_din   (cpu_din)
    );

endmodule
